//--- design/rs_pkg.sv
`default_nettype none

package rs_pkg;

  localparam int word_w    = 32;
  localparam int num_regs  = 16;
  localparam int num_slots = 4;

  typedef logic [3:0] reg_idx_t;
  typedef logic [1:0] slot_idx_t;

  typedef enum logic [1:0] {
    unit_none = 2'd0, // value sits in the register file
    unit_add  = 2'd1,
    unit_mul  = 2'd2
  } unit_e;

  // one tag word, compared raw or split for routing
  typedef union packed {
    logic [3:0] raw;
    struct packed {
      unit_e     unit;
      slot_idx_t slot;
    } f;
  } tag_u;

  localparam tag_u tag_ready = '0;

  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_mul = 2'd1,
    op_mv  = 2'd2
  } op_e;

  typedef struct packed {
    logic              busy;
    tag_u              tag1;
    tag_u              tag2;
    logic [word_w-1:0] val1;
    logic [word_w-1:0] val2;
  } rs_entry_t;

  // index of lowest set bit, zero when none
  function automatic slot_idx_t lowest_slot(logic [num_slots-1:0] mask);
    slot_idx_t idx;
    idx = '0;
    for (int i = num_slots - 1; i >= 0; i--) begin
      if (mask[i]) idx = slot_idx_t'(i);
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

//--- design/alloc_if.sv
`timescale 1ns/10ps
`default_nettype none

interface alloc_if import rs_pkg::*; ();

  logic                 alloc_valid; // single-cycle write strobe
  slot_idx_t            alloc_slot;
  rs_entry_t            alloc_entry;
  logic [num_slots-1:0] free_mask;   // one bit per idle station

  modport issuer (
    output alloc_valid,
    output alloc_slot,
    output alloc_entry,
    input  free_mask
  );

  modport bank (
    input  alloc_valid,
    input  alloc_slot,
    input  alloc_entry,
    output free_mask
  );

endinterface

`default_nettype wire

//--- design/issue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module issue_ctrl import rs_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req,
  output logic              ack,
  input  op_e               op,
  input  reg_idx_t          rd,
  input  reg_idx_t          rs1,
  input  reg_idx_t          rs2,
  input  logic              has_imm,
  input  logic [word_w-1:0] imm,
  alloc_if.issuer           alloc_add,
  alloc_if.issuer           alloc_mul,
  input  tag_u              rd_tag1,
  input  tag_u              rd_tag2,
  input  logic [word_w-1:0] rd_val1,
  input  logic [word_w-1:0] rd_val2,
  output reg_idx_t          src1,
  output reg_idx_t          src2,
  output logic              ren_valid,
  output reg_idx_t          ren_reg,
  output tag_u              ren_tag,
  output logic              imm_wr,
  input  logic              cdb_valid,
  input  tag_u              cdb_tag,
  input  logic [word_w-1:0] cdb_value
);

  logic                 to_add;
  logic                 to_mul;
  logic [num_slots-1:0] tgt_free;
  slot_idx_t            free_slot;
  logic                 slot_ok;
  logic                 accept;
  unit_e                tgt_unit;
  rs_entry_t            entry;

  function automatic logic on_bus(tag_u t);
    return cdb_valid && (cdb_tag.raw == t.raw);
  endfunction

  // register move rides an add station
  assign to_add   = (op == op_add) || (op == op_mv && !has_imm);
  assign to_mul   = (op == op_mul);
  assign tgt_unit = to_mul ? unit_mul : unit_add;

  assign tgt_free  = to_mul ? alloc_mul.free_mask : alloc_add.free_mask;
  assign free_slot = lowest_slot(tgt_free);
  assign slot_ok   = !(to_add || to_mul) || (|tgt_free); // imm move never stalls
  assign accept    = req && !ack && slot_ok;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
    end else if (accept) begin
      ack <= 1'b1;
    end else if (ack && !req) begin
      ack <= 1'b0;
    end
  end

  assign src1 = rs1;
  assign src2 = rs2;

  // status lookup, result on the bus this cycle counts as ready
  always_comb begin
    entry      = '0;
    entry.busy = 1'b1;
    entry.tag1 = rd_tag1;
    entry.val1 = rd_val1;
    if (on_bus(rd_tag1)) begin
      entry.tag1 = tag_ready;
      entry.val1 = cdb_value;
    end
    if (op == op_mv) begin
      entry.tag2 = tag_ready; // zero second operand
      entry.val2 = '0;
    end else if (has_imm) begin
      entry.tag2 = tag_ready;
      entry.val2 = imm;
    end else if (on_bus(rd_tag2)) begin
      entry.tag2 = tag_ready;
      entry.val2 = cdb_value;
    end else begin
      entry.tag2 = rd_tag2;
      entry.val2 = rd_val2;
    end
  end

  assign alloc_add.alloc_valid = accept && to_add;
  assign alloc_add.alloc_slot  = free_slot;
  assign alloc_add.alloc_entry = entry;
  assign alloc_mul.alloc_valid = accept && to_mul;
  assign alloc_mul.alloc_slot  = free_slot;
  assign alloc_mul.alloc_entry = entry;

  always_comb begin
    ren_valid       = accept && (to_add || to_mul);
    ren_reg         = rd;
    ren_tag.f.unit  = tgt_unit;
    ren_tag.f.slot  = free_slot;
    imm_wr          = accept && (op == op_mv) && has_imm;
  end

endmodule

`default_nettype wire

//--- design/station_bank.sv
`timescale 1ns/10ps
`default_nettype none

module station_bank import rs_pkg::*; #(
  parameter unit_e unit = unit_add
) (
  input  logic              clk,
  input  logic              arst_n,
  alloc_if.bank             alloc,
  input  logic              cdb_valid,
  input  tag_u              cdb_tag,
  input  logic [word_w-1:0] cdb_value,
  output logic              done_req,
  output slot_idx_t         done_slot,
  output logic [word_w-1:0] done_value,
  input  logic              done_grant
);

  rs_entry_t            slots [num_slots];
  logic [num_slots-1:0] busy;
  logic [num_slots-1:0] ready;
  logic                 any_ready;
  slot_idx_t            pick;
  logic                 held;      // a request is waiting for its grant
  slot_idx_t            held_slot;
  logic [word_w-1:0]    op_a;
  logic [word_w-1:0]    op_b;

  assign alloc.free_mask = ~busy;

  // entry payload and bus capture
  always_ff @(posedge clk) begin
    if (alloc.alloc_valid) begin
      slots[alloc.alloc_slot] <= alloc.alloc_entry;
    end
    for (int i = 0; i < num_slots; i++) begin
      if (cdb_valid && slots[i].tag1.raw == cdb_tag.raw) begin
        slots[i].tag1 <= tag_ready;
        slots[i].val1 <= cdb_value;
      end
      if (cdb_valid && slots[i].tag2.raw == cdb_tag.raw) begin
        slots[i].tag2 <= tag_ready;
        slots[i].val2 <= cdb_value;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < num_slots; i++) begin
      ready[i] = busy[i] && slots[i].tag1.raw == tag_ready.raw &&
                 slots[i].tag2.raw == tag_ready.raw;
    end
  end

  assign any_ready = |ready;
  assign pick      = lowest_slot(ready);

  // a lower slot turning ready must not replace the pending one
  assign done_req  = held || any_ready;
  assign done_slot = held ? held_slot : pick;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= '0;
      held      <= 1'b0;
      held_slot <= '0;
    end else begin
      if (alloc.alloc_valid) begin
        busy[alloc.alloc_slot] <= alloc.alloc_entry.busy;
      end
      if (done_grant) begin
        busy[done_slot] <= 1'b0; // result leaves on the bus next cycle
        held            <= 1'b0;
      end else if (done_req) begin
        held      <= 1'b1;
        held_slot <= done_slot;
      end
    end
  end

  assign op_a = slots[done_slot].val1;
  assign op_b = slots[done_slot].val2;

  generate
    if (unit == unit_mul) begin : g_mul
      assign done_value = $signed(op_a) * $signed(op_b); // low word only
    end else begin : g_add
      assign done_value = op_a + op_b;
    end
  endgenerate

endmodule

`default_nettype wire

//--- design/cdb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter import rs_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              add_req,
  input  slot_idx_t         add_slot,
  input  logic [word_w-1:0] add_value,
  input  logic              mul_req,
  input  slot_idx_t         mul_slot,
  input  logic [word_w-1:0] mul_value,
  output logic              add_grant,
  output logic              mul_grant,
  output logic              cdb_valid,
  output tag_u              cdb_tag,
  output logic [word_w-1:0] cdb_value
);

  tag_u              tag_d;
  logic [word_w-1:0] value_d;

  // fixed priority, mul wins
  assign mul_grant = mul_req;
  assign add_grant = add_req && !mul_req;

  always_comb begin
    tag_d.f.unit = mul_req ? unit_mul : unit_add;
    tag_d.f.slot = mul_req ? mul_slot : add_slot;
    value_d      = mul_req ? mul_value : add_value;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= add_req || mul_req;
    end
  end

  always_ff @(posedge clk) begin
    cdb_tag   <= tag_d;
    cdb_value <= value_d;
  end

endmodule

`default_nettype wire

//--- design/reg_status.sv
`timescale 1ns/10ps
`default_nettype none

module reg_status import rs_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  reg_idx_t          src1,
  input  reg_idx_t          src2,
  input  reg_idx_t          query_reg,
  output tag_u              rd_tag1,
  output tag_u              rd_tag2,
  output logic [word_w-1:0] rd_val1,
  output logic [word_w-1:0] rd_val2,
  output logic [word_w-1:0] query_value,
  output logic              query_busy,
  input  logic              ren_valid,
  input  reg_idx_t          ren_reg,
  input  tag_u              ren_tag,
  input  logic              imm_wr,
  input  logic [word_w-1:0] imm,
  input  logic              cdb_valid,
  input  tag_u              cdb_tag,
  input  logic [word_w-1:0] cdb_value
);

  logic [word_w-1:0] regs   [num_regs];
  tag_u              status [num_regs];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i]   <= '0;
        status[i] <= tag_ready;
      end
    end else begin
      // retire only where the producer is still the latest one
      if (cdb_valid) begin
        for (int i = 0; i < num_regs; i++) begin
          if (status[i].raw == cdb_tag.raw) begin
            status[i] <= tag_ready;
            regs[i]   <= cdb_value;
          end
        end
      end
      // issue writes come last so they override retirement
      if (ren_valid) begin
        status[ren_reg] <= ren_tag;
      end
      if (imm_wr) begin
        status[ren_reg] <= tag_ready;
        regs[ren_reg]   <= imm;
      end
    end
  end

  assign rd_tag1 = status[src1];
  assign rd_tag2 = status[src2];
  assign rd_val1 = regs[src1];
  assign rd_val2 = regs[src2];

  assign query_value = regs[query_reg];
  assign query_busy  = status[query_reg].raw != tag_ready.raw; // producer pending

endmodule

`default_nettype wire

//--- design/rs_core.sv
`timescale 1ns/10ps
`default_nettype none

module rs_core import rs_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req,
  output logic              ack,
  input  op_e               op,
  input  reg_idx_t          rd,
  input  reg_idx_t          rs1,
  input  reg_idx_t          rs2,
  input  logic              has_imm,
  input  logic [word_w-1:0] imm,
  input  reg_idx_t          query_reg,
  output logic [word_w-1:0] query_value,
  output logic              query_busy
);

  alloc_if alloc_add ();
  alloc_if alloc_mul ();

  tag_u              rd_tag1;
  tag_u              rd_tag2;
  logic [word_w-1:0] rd_val1;
  logic [word_w-1:0] rd_val2;
  reg_idx_t          src1;
  reg_idx_t          src2;
  logic              ren_valid;
  reg_idx_t          ren_reg;
  tag_u              ren_tag;
  logic              imm_wr;

  logic              cdb_valid;
  tag_u              cdb_tag;
  logic [word_w-1:0] cdb_value;

  logic              add_req;
  slot_idx_t         add_slot;
  logic [word_w-1:0] add_value;
  logic              add_grant;
  logic              mul_req;
  slot_idx_t         mul_slot;
  logic [word_w-1:0] mul_value;
  logic              mul_grant;

  issue_ctrl issue_ctrl_i (
    .clk, .arst_n, .req, .ack, .op, .rd, .rs1, .rs2, .has_imm, .imm,
    .alloc_add (alloc_add.issuer),
    .alloc_mul (alloc_mul.issuer),
    .rd_tag1, .rd_tag2, .rd_val1, .rd_val2, .src1, .src2,
    .ren_valid, .ren_reg, .ren_tag, .imm_wr,
    .cdb_valid, .cdb_tag, .cdb_value
  );

  station_bank #(.unit(unit_add)) add_bank (
    .clk, .arst_n, .alloc (alloc_add.bank),
    .cdb_valid, .cdb_tag, .cdb_value,
    .done_req (add_req), .done_slot (add_slot), .done_value (add_value),
    .done_grant (add_grant)
  );

  station_bank #(.unit(unit_mul)) mul_bank (
    .clk, .arst_n, .alloc (alloc_mul.bank),
    .cdb_valid, .cdb_tag, .cdb_value,
    .done_req (mul_req), .done_slot (mul_slot), .done_value (mul_value),
    .done_grant (mul_grant)
  );

  cdb_arbiter cdb_arbiter_i (
    .clk, .arst_n,
    .add_req, .add_slot, .add_value, .mul_req, .mul_slot, .mul_value,
    .add_grant, .mul_grant, .cdb_valid, .cdb_tag, .cdb_value
  );

  reg_status reg_status_i (
    .clk, .arst_n, .src1, .src2, .query_reg,
    .rd_tag1, .rd_tag2, .rd_val1, .rd_val2, .query_value, .query_busy,
    .ren_valid, .ren_reg, .ren_tag, .imm_wr, .imm,
    .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  localparam int half_period  = 50; // 100 ns clock
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #10 arst_n = 1'b1; // release away from the edge
  end

endmodule

`default_nettype wire

//--- verif/rs_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rs_core_tb import rs_pkg::*; ();

  localparam int drive_delay = 10;
  localparam int wait_limit  = 200; // cycles per wait

  logic              clk;
  logic              arst_n;
  logic              req;
  logic              ack;
  op_e               op;
  reg_idx_t          rd;
  reg_idx_t          rs1;
  reg_idx_t          rs2;
  logic              has_imm;
  logic [word_w-1:0] imm;
  reg_idx_t          query_reg;
  logic [word_w-1:0] query_value;
  logic              query_busy;

  logic [word_w-1:0] model [num_regs]; // architectural state in program order
  logic [31:0]       rng;

  tb_clk_gen clk_gen_i (.clk, .arst_n);

  rs_core rs_core_i (
    .clk, .arst_n, .req, .ack, .op, .rd, .rs1, .rs2, .has_imm, .imm,
    .query_reg, .query_value, .query_busy
  );

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [word_w-1:0] ref_result(op_e o, logic [word_w-1:0] a,
                                                   logic [word_w-1:0] b, logic use_imm,
                                                   logic [word_w-1:0] k);
    logic [word_w-1:0]  src_b;
    logic signed [63:0] prod;
    src_b = use_imm ? k : b;
    prod  = $signed(a) * $signed(src_b);
    case (o)
      op_add:  return a + src_b;
      op_mul:  return prod[word_w-1:0]; // low word of signed product
      default: return use_imm ? k : a;
    endcase
  endfunction

  task automatic check_value(string name, logic [word_w-1:0] actual,
                             logic [word_w-1:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
               $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic timeout_fail(string what);
    $display("timed out at %0d ns while waiting for %s", $time, what);
    $display("Test failed");
    $fatal(1, "wait timeout");
  endtask

  task automatic next_drive_point();
    @(posedge clk);
    #drive_delay;
  endtask

  // four-phase issue, model follows at acceptance
  task automatic issue_instr(op_e o, reg_idx_t d, reg_idx_t s1, reg_idx_t s2,
                             logic use_imm, logic [word_w-1:0] k);
    int n;
    op      = o;
    rd      = d;
    rs1     = s1;
    rs2     = s2;
    has_imm = use_imm;
    imm     = k;
    req     = 1'b1;
    n = 0;
    while (!ack) begin
      if (n == wait_limit) timeout_fail("ack to rise");
      next_drive_point();
      n++;
    end
    model[d] = ref_result(o, model[s1], model[s2], use_imm, k);
    req       = 1'b0;
    query_reg = d; // rename or direct write landed at acceptance
    @(negedge clk);
    if (o == op_mv && use_imm) begin
      check_value($sformatf("query_busy of r%0d", d), {31'b0, query_busy}, '0);
      check_value($sformatf("r%0d", d), query_value, k);
    end else begin
      check_value($sformatf("query_busy of r%0d", d), {31'b0, query_busy}, 32'd1);
    end
    n = 0;
    while (ack) begin
      if (n == wait_limit) timeout_fail("ack to fall");
      next_drive_point();
      n++;
    end
  endtask

  task automatic check_idle_regs();
    for (int r = 0; r < num_regs; r++) begin
      query_reg = reg_idx_t'(r);
      @(negedge clk);
      check_value($sformatf("query_busy of r%0d", r), {31'b0, query_busy}, '0);
      check_value($sformatf("r%0d", r), query_value, '0);
      next_drive_point();
    end
  endtask

  task automatic compare_regs();
    int n;
    for (int r = 0; r < num_regs; r++) begin
      query_reg = reg_idx_t'(r);
      n = 0;
      @(negedge clk);
      while (query_busy) begin
        if (n == wait_limit) timeout_fail($sformatf("r%0d to retire", r));
        @(negedge clk);
        n++;
      end
      check_value($sformatf("r%0d", r), query_value, model[r]);
      next_drive_point();
    end
  endtask

  initial begin
    int   n;
    op_e  rand_op;
    req        = 1'b0;
    op         = op_add;
    rd         = '0;
    rs1        = '0;
    rs2        = '0;
    has_imm    = 1'b0;
    imm        = '0;
    query_reg  = '0;
    rng        = 32'ha12e;
    for (int r = 0; r < num_regs; r++) model[r] = '0;

    n = 0;
    while (arst_n !== 1'b1) begin
      if (n == wait_limit) timeout_fail("reset release");
      @(posedge clk);
      n++;
    end
    next_drive_point();

    check_idle_regs();

    for (int r = 0; r < num_regs; r++) begin
      rng = lcg_next(rng);
      issue_instr(op_mv, reg_idx_t'(r), 4'd0, 4'd0, 1'b1, rng);
    end
    compare_regs();

    // chain through earlier destinations
    issue_instr(op_add, 4'd1, 4'd2, 4'd3, 1'b0, '0);
    issue_instr(op_mul, 4'd4, 4'd1, 4'd2, 1'b0, '0);
    issue_instr(op_add, 4'd5, 4'd4, 4'd0, 1'b1, 32'd7);
    issue_instr(op_mv,  4'd6, 4'd5, 4'd0, 1'b0, '0);
    issue_instr(op_mul, 4'd7, 4'd6, 4'd4, 1'b0, '0);
    issue_instr(op_add, 4'd1, 4'd7, 4'd1, 1'b0, '0);
    compare_regs();

    // mul burst, each one feeds the next
    for (int i = 0; i < 6; i++) begin
      issue_instr(op_mul, reg_idx_t'(8 + i), reg_idx_t'(7 + i), 4'd3, 1'b0, '0);
    end
    compare_regs();

    // younger writer over a pending producer
    issue_instr(op_mul, 4'd9, 4'd8, 4'd8, 1'b0, '0);
    issue_instr(op_mv,  4'd9, 4'd0, 4'd0, 1'b1, 32'hcafe_0009);
    issue_instr(op_mul, 4'd10, 4'd9, 4'd11, 1'b0, '0);
    issue_instr(op_add, 4'd10, 4'd2, 4'd3, 1'b1, 32'h5);
    compare_regs();

    for (int i = 0; i < 200; i++) begin
      rng = lcg_next(rng);
      case (rng[31:30])
        2'd1:    rand_op = op_mul;
        2'd2:    rand_op = op_mv;
        default: rand_op = op_add;
      endcase
      rd      = rng[27:24];
      rs1     = rng[23:20];
      rs2     = rng[19:16];
      has_imm = rng[15];
      rng = lcg_next(rng);
      issue_instr(rand_op, rd, rs1, rs2, has_imm, rng);
    end
    compare_regs();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- rs_core.f
design/rs_pkg.sv
design/alloc_if.sv
design/issue_ctrl.sv
design/station_bank.sv
design/cdb_arbiter.sv
design/reg_status.sv
design/rs_core.sv
verif/tb_clk_gen.sv
verif/rs_core_tb.sv

//--- Bender.yml
package:
  name: rs_core

dependencies: {}

sources:
  - files:
      - design/rs_pkg.sv
      - design/alloc_if.sv
      - design/issue_ctrl.sv
      - design/station_bank.sv
      - design/cdb_arbiter.sv
      - design/reg_status.sv
      - design/rs_core.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/rs_core_tb.sv
